//--- hw/ppuPkg.sv
package ppuPkg;

    // raster timing, pixels per line
    localparam int H_ACTIVE = 128;
    localparam int H_FRONT  = 8;
    localparam int H_SYNC   = 16;
    localparam int H_TOTAL  = 160;

    // lines per frame
    localparam int V_ACTIVE = 96;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 104;

    // game window placement
    localparam int GAME_X    = 32;
    localparam int GAME_Y    = 16;
    localparam int GAME_SIZE = 64;

    localparam int TILE_SIZE     = 8;
    localparam int TILES_PER_ROW = 8;
    localparam int NAME_ENTRIES  = TILES_PER_ROW * TILES_PER_ROW;
    localparam int NAME_AW       = $clog2(NAME_ENTRIES);
    localparam int TILE_IDX_W    = 4;      // palette index held per tile
    localparam int PALETTE_ENTRIES = 16;
    localparam int PALETTE_AW    = $clog2(PALETTE_ENTRIES);

    localparam int SPRITE_COUNT = 8;
    localparam int SPRITE_SIZE  = 8;
    localparam int SPRITE_AW    = $clog2(SPRITE_COUNT);

    // sprite word layout
    localparam int SPR_EN_BIT = 31;
    localparam int SPR_Y_MSB  = 29;
    localparam int SPR_Y_LSB  = 24;
    localparam int SPR_X_MSB  = 21;
    localparam int SPR_X_LSB  = 16;
    localparam int SPR_C_MSB  = 11;
    localparam int SPR_C_LSB  = 0;

    localparam int POSX_W = 8;
    localparam int POSY_W = 7;
    localparam int WIN_W  = 6;
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int RGB_W  = 12;

    typedef logic [RGB_W-1:0] rgb_t;

    localparam rgb_t BORDER_COLOR = 12'h36a;

    typedef enum logic [1:0] {WR_NAME, WR_PALETTE, WR_SPRITE} wrTarget_t;

    typedef enum logic [1:0] {FS_IDLE, FS_DRAW, FS_IRQ, FS_VBLANK} frameState_t;

endpackage

//--- hw/scanIf.sv
`timescale 1ns/1ps

interface scanIf
    import ppuPkg::*;
();
    logic              pixelEn;
    logic [POSX_W-1:0] posX;
    logic [POSY_W-1:0] posY;
    logic [WIN_W-1:0]  winX;    // window relative, valid with inWindow
    logic [WIN_W-1:0]  winY;
    logic              activeVideo;
    logic              inWindow;
    logic              hsync;   // active low
    logic              vsync;   // active low

    modport timer (output pixelEn, posX, posY, winX, winY, activeVideo, inWindow, hsync, vsync);
    modport monitor (input pixelEn, posX, posY);
    modport consumer (input winX, winY, activeVideo, inWindow, hsync, vsync);

endinterface

//--- hw/scanTimer.sv
`timescale 1ns/1ps

module scanTimer
    import ppuPkg::*;
(
    input  logic clk_50MHz,
    input  logic rstn,
    scanIf.timer scan
);

    logic              pixelEn;
    logic [POSX_W-1:0] hCnt;
    logic [POSY_W-1:0] vCnt;
    logic              lineEnd;
    logic              frameEnd;

    assign lineEnd  = hCnt == POSX_W'(H_TOTAL - 1);
    assign frameEnd = vCnt == POSY_W'(V_TOTAL - 1);

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            pixelEn <= 1'b0;
            hCnt    <= '0;
            vCnt    <= '0;
        end else begin
            pixelEn <= ~pixelEn;  // half rate pixel clock
            if (pixelEn) begin
                if (lineEnd) begin
                    hCnt <= '0;
                    vCnt <= frameEnd ? '0 : vCnt + 1'b1;
                end else begin
                    hCnt <= hCnt + 1'b1;
                end
            end
        end
    end

    assign scan.pixelEn = pixelEn;
    assign scan.posX    = hCnt;
    assign scan.posY    = vCnt;

    assign scan.activeVideo = (hCnt < POSX_W'(H_ACTIVE)) && (vCnt < POSY_W'(V_ACTIVE));

    // sync placed after the front porch
    assign scan.hsync = !((hCnt >= POSX_W'(H_ACTIVE + H_FRONT)) &&
                          (hCnt <  POSX_W'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign scan.vsync = !((vCnt >= POSY_W'(V_ACTIVE + V_FRONT)) &&
                          (vCnt <  POSY_W'(V_ACTIVE + V_FRONT + V_SYNC)));

    assign scan.inWindow = (hCnt >= POSX_W'(GAME_X)) && (hCnt < POSX_W'(GAME_X + GAME_SIZE)) &&
                           (vCnt >= POSY_W'(GAME_Y)) && (vCnt < POSY_W'(GAME_Y + GAME_SIZE));

    assign scan.winX = WIN_W'(hCnt - POSX_W'(GAME_X));
    assign scan.winY = WIN_W'(vCnt - POSY_W'(GAME_Y));

endmodule

//--- hw/frameSequencer.sv
`timescale 1ns/1ps

module frameSequencer
    import ppuPkg::*;
(
    input  logic   clk_50MHz,
    input  logic   rstn,
    scanIf.monitor scan,
    output logic   vgaIntr,
    output logic   commit
);

    frameState_t state;
    frameState_t stateNext;
    logic        stepIrq;
    logic        stepVblank;
    logic        atOrigin;

    // scan leaves the window's last pixel on this clock
    assign stepIrq = scan.pixelEn &&
                     (scan.posX == POSX_W'(GAME_X + GAME_SIZE - 1)) &&
                     (scan.posY == POSY_W'(GAME_Y + GAME_SIZE - 1));

    // last pixel of the last active line
    assign stepVblank = scan.pixelEn &&
                        (scan.posX == POSX_W'(H_TOTAL - 1)) &&
                        (scan.posY == POSY_W'(V_ACTIVE - 1));

    assign atOrigin = (scan.posX == '0) && (scan.posY == '0);

    always_comb begin
        stateNext = state;
        case (state)
            FS_IDLE: begin
                if (atOrigin)
                    stateNext = FS_DRAW;
            end
            FS_DRAW: begin
                if (stepIrq)
                    stateNext = FS_IRQ;
                else if (stepVblank)
                    stateNext = FS_VBLANK;
            end
            FS_IRQ:    stateNext = FS_DRAW;  // single clock
            FS_VBLANK: begin
                if (scan.posY == '0)
                    stateNext = FS_DRAW;
            end
            default:   stateNext = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            state  <= FS_IDLE;
            commit <= 1'b0;
        end else begin
            state  <= stateNext;
            commit <= (stateNext == FS_VBLANK) && (state != FS_VBLANK);
        end
    end

    assign vgaIntr = state == FS_IRQ;

endmodule

//--- hw/backgroundEngine.sv
`timescale 1ns/1ps

module backgroundEngine
    import ppuPkg::*;
(
    input  logic              clk_50MHz,
    input  logic              rstn,
    scanIf.consumer           scan,
    input  logic              wrEn,
    input  wrTarget_t         wrTarget,
    input  logic [ADDR_W-1:0] wrAddr,
    input  logic [DATA_W-1:0] wrData,
    output rgb_t              bgColor
);

    logic [TILE_IDX_W-1:0] nameTbl [NAME_ENTRIES];
    rgb_t                  palette [PALETTE_ENTRIES];
    logic [NAME_AW-1:0]    tileIdx;
    logic                  nameWr;
    logic                  palWr;

    assign nameWr = wrEn && (wrTarget == WR_NAME) && (wrAddr < ADDR_W'(NAME_ENTRIES));
    assign palWr  = wrEn && (wrTarget == WR_PALETTE) && (wrAddr < ADDR_W'(PALETTE_ENTRIES));

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            for (int i = 0; i < NAME_ENTRIES; i++) begin
                nameTbl[i] <= '0;
            end
            for (int i = 0; i < PALETTE_ENTRIES; i++) begin
                palette[i] <= '0;
            end
        end else begin
            if (nameWr)
                nameTbl[wrAddr[NAME_AW-1:0]] <= wrData[TILE_IDX_W-1:0];
            if (palWr)
                palette[wrAddr[PALETTE_AW-1:0]] <= wrData[RGB_W-1:0];
        end
    end

    // row of tiles then column
    assign tileIdx = NAME_AW'((scan.winY / TILE_SIZE) * TILES_PER_ROW + scan.winX / TILE_SIZE);

    always_ff @(posedge clk_50MHz) begin
        if (!rstn)
            bgColor <= '0;
        else
            bgColor <= palette[nameTbl[tileIdx]];
    end

endmodule

//--- hw/spriteEngine.sv
`timescale 1ns/1ps

module spriteEngine
    import ppuPkg::*;
(
    input  logic              clk_50MHz,
    input  logic              rstn,
    scanIf.consumer           scan,
    input  logic              wrEn,
    input  wrTarget_t         wrTarget,
    input  logic [ADDR_W-1:0] wrAddr,
    input  logic [DATA_W-1:0] wrData,
    input  logic              commit,
    output rgb_t              spriteColor
);

    logic [DATA_W-1:0] shadowTbl [SPRITE_COUNT];
    logic [DATA_W-1:0] liveTbl   [SPRITE_COUNT];
    logic              sprWr;
    rgb_t              hitColor;

    assign sprWr = wrEn && (wrTarget == WR_SPRITE) && (wrAddr < ADDR_W'(SPRITE_COUNT));

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            for (int i = 0; i < SPRITE_COUNT; i++) begin
                shadowTbl[i] <= '0;
                liveTbl[i]   <= '0;
            end
        end else begin
            if (sprWr)
                shadowTbl[wrAddr[SPRITE_AW-1:0]] <= wrData;
            if (commit)
                liveTbl <= shadowTbl;  // whole table at once, no tearing
        end
    end

    function automatic logic spriteHit(
        input logic [DATA_W-1:0] spr,
        input logic [WIN_W-1:0]  wx,
        input logic [WIN_W-1:0]  wy
    );
        logic [WIN_W:0] dx;
        logic [WIN_W:0] dy;
        // negative offsets wrap high and fail the size test
        dx = {1'b0, wx} - {1'b0, spr[SPR_X_MSB:SPR_X_LSB]};
        dy = {1'b0, wy} - {1'b0, spr[SPR_Y_MSB:SPR_Y_LSB]};
        return spr[SPR_EN_BIT] &&
               (dx < (WIN_W+1)'(SPRITE_SIZE)) &&
               (dy < (WIN_W+1)'(SPRITE_SIZE)) &&
               (spr[SPR_C_MSB:SPR_C_LSB] != '0);
    endfunction

    // highest index first so the lowest hit is left standing
    always_comb begin
        hitColor = '0;
        for (int i = SPRITE_COUNT - 1; i >= 0; i--) begin
            if (spriteHit(liveTbl[i], scan.winX, scan.winY))
                hitColor = liveTbl[i][SPR_C_MSB:SPR_C_LSB];
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!rstn)
            spriteColor <= '0;
        else
            spriteColor <= scan.inWindow ? hitColor : '0;
    end

endmodule

//--- hw/pixelMixer.sv
`timescale 1ns/1ps

module pixelMixer
    import ppuPkg::*;
(
    input  logic    clk_50MHz,
    input  logic    rstn,
    scanIf.consumer scan,
    input  rgb_t    bgColor,
    input  rgb_t    spriteColor,
    output rgb_t    rgb,
    output logic    hsync,
    output logic    vsync
);

    logic activeVideoD;
    logic inWindowD;
    logic hsyncD;
    logic vsyncD;

    // stage one lines up with the engine registers
    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            activeVideoD <= 1'b0;
            inWindowD    <= 1'b0;
            hsyncD       <= 1'b1;
            vsyncD       <= 1'b1;
        end else begin
            activeVideoD <= scan.activeVideo;
            inWindowD    <= scan.inWindow;
            hsyncD       <= scan.hsync;
            vsyncD       <= scan.vsync;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= hsyncD;
            vsync <= vsyncD;
            if (!activeVideoD)
                rgb <= '0;                 // blanking
            else if (!inWindowD)
                rgb <= BORDER_COLOR;
            else if (spriteColor != '0)
                rgb <= spriteColor;        // sprite over background
            else
                rgb <= bgColor;
        end
    end

endmodule

//--- hw/ppuTop.sv
`timescale 1ns/1ps

module ppuTop
    import ppuPkg::*;
(
    input  logic              clk_50MHz,
    input  logic              rstn,
    input  logic              wrEn,
    input  wrTarget_t         wrTarget,
    input  logic [ADDR_W-1:0] wrAddr,
    input  logic [DATA_W-1:0] wrData,
    output rgb_t              rgb,
    output logic              hsync,
    output logic              vsync,
    output logic              vgaIntr
);

    rgb_t bgColor;
    rgb_t spriteColor;
    logic commit;

    scanIf scan ();

    scanTimer u_scanTimer (
        .clk_50MHz (clk_50MHz),
        .rstn      (rstn),
        .scan      (scan)
    );

    frameSequencer u_frameSequencer (
        .clk_50MHz (clk_50MHz),
        .rstn      (rstn),
        .scan      (scan),
        .vgaIntr   (vgaIntr),
        .commit    (commit)
    );

    backgroundEngine u_backgroundEngine (
        .clk_50MHz (clk_50MHz),
        .rstn      (rstn),
        .scan      (scan),
        .wrEn      (wrEn),
        .wrTarget  (wrTarget),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .bgColor   (bgColor)
    );

    spriteEngine u_spriteEngine (
        .clk_50MHz   (clk_50MHz),
        .rstn        (rstn),
        .scan        (scan),
        .wrEn        (wrEn),
        .wrTarget    (wrTarget),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .commit      (commit),
        .spriteColor (spriteColor)
    );

    pixelMixer u_pixelMixer (
        .clk_50MHz   (clk_50MHz),
        .rstn        (rstn),
        .scan        (scan),
        .bgColor     (bgColor),
        .spriteColor (spriteColor),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync)
    );

endmodule

//--- sim/ppuProps.sv
`timescale 1ns/1ps

module ppuProps
    import ppuPkg::*;
(
    input logic clk_50MHz,
    input logic rstn,
    input logic vgaIntr,
    input logic commit,
    input logic activeVideoD,
    input rgb_t rgb
);

    irqOneClock: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        vgaIntr |=> !vgaIntr)
        else $error("vgaIntr high on two consecutive clocks");

    // rgb is registered one clock after the delayed flag
    blankIsBlack: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        !activeVideoD |=> rgb == '0)
        else $error("rgb not black during blanking");

    commitInBlank: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        commit |-> !activeVideoD)
        else $error("sprite commit during active video");

endmodule

// spans the mixer and the sequencer, so it sits at the top
bind ppuTop ppuProps u_props (
    .clk_50MHz    (clk_50MHz),
    .rstn         (rstn),
    .vgaIntr      (vgaIntr),
    .commit       (commit),
    .activeVideoD (u_pixelMixer.activeVideoD),
    .rgb          (rgb)
);

//--- sim/tb_ppuTop.sv
`timescale 1ns/1ps

module tb_ppuTop
    import ppuPkg::*;
();

    localparam int FRAME_CLKS   = 2 * H_TOTAL * V_TOTAL;
    localparam int LINE_CLKS    = 2 * H_TOTAL;
    localparam int VBLANK_LINES = V_TOTAL - V_ACTIVE - V_FRONT;
    localparam int IRQ_CLKS     = 2 * (VBLANK_LINES * H_TOTAL + (GAME_Y + GAME_SIZE - 1) * H_TOTAL
                                  + GAME_X + GAME_SIZE) - 2;
    localparam int LATE_CLKS    = 2 * (VBLANK_LINES * H_TOTAL + 20 * H_TOTAL);  // active line 20
    localparam int N_WR         = 11;
    localparam int N_CHK        = 14;

    logic              clk_50MHz;
    logic              rstn;
    logic              wrEn;
    wrTarget_t         wrTarget;
    logic [ADDR_W-1:0] wrAddr;
    logic [DATA_W-1:0] wrData;
    rgb_t              rgb;
    logic              hsync;
    logic              vsync;
    logic              vgaIntr;

    wrTarget_t         wrTgtTbl  [N_WR];
    logic [ADDR_W-1:0] wrAddrTbl [N_WR];
    logic [DATA_W-1:0] wrDataTbl [N_WR];
    int                chkX      [N_CHK];
    int                chkY      [N_CHK];
    rgb_t              expFirst  [N_CHK];
    rgb_t              expSecond [N_CHK];

    integer seed;
    rgb_t   randColor;
    int     errors;
    int     checks;
    int     tests;
    bit     timedOut;

    ppuTop u_dut (
        .clk_50MHz (clk_50MHz),
        .rstn      (rstn),
        .wrEn      (wrEn),
        .wrTarget  (wrTarget),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .rgb       (rgb),
        .hsync     (hsync),
        .vsync     (vsync),
        .vgaIntr   (vgaIntr)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    function automatic logic [DATA_W-1:0] packSprite(input logic en, input int x, input int y,
                                                     input rgb_t c);
        logic [DATA_W-1:0] w;
        w = '0;
        w[SPR_EN_BIT] = en;
        w[SPR_Y_MSB:SPR_Y_LSB] = 6'(y);
        w[SPR_X_MSB:SPR_X_LSB] = 6'(x);
        w[SPR_C_MSB:SPR_C_LSB] = c;
        return w;
    endfunction

    function automatic logic syncLevel(input bit useV);
        return useV ? vsync : hsync;
    endfunction

    task automatic addWrite(input int i, input wrTarget_t t, input int a, input logic [31:0] d);
        wrTgtTbl[i]  = t;
        wrAddrTbl[i] = 8'(a);
        wrDataTbl[i] = d;
    endtask

    task automatic addCheck(input int i, input int x, input int y, input rgb_t e1, input rgb_t e2);
        chkX[i]      = x;
        chkY[i]      = y;
        expFirst[i]  = e1;
        expSecond[i] = e2;
    endtask

    task automatic buildTables();
        addWrite(0, WR_PALETTE, 0, 32'h111);
        addWrite(1, WR_PALETTE, 1, 32'hf00);
        addWrite(2, WR_PALETTE, 2, {20'h0, randColor});
        addWrite(3, WR_PALETTE, 3, 32'h0f0);
        addWrite(4, WR_NAME, 0, 32'd1);
        addWrite(5, WR_NAME, 9, 32'd2);
        addWrite(6, WR_NAME, 63, 32'd3);
        addWrite(7, WR_SPRITE, 1, packSprite(1'b1, 24, 24, 12'habc));
        addWrite(8, WR_SPRITE, 2, packSprite(1'b1, 28, 28, 12'h5a5));  // overlaps sprite 1
        addWrite(9, WR_SPRITE, 0, packSprite(1'b1, 20, 20, 12'h000));  // colour 0, under sprite 1
        addWrite(10, WR_SPRITE, 5, packSprite(1'b0, 48, 8, 12'hfff));  // disabled
        // screen position = window position + (32,16)
        addCheck(0, 32, 16, 12'hf00, 12'hf00);
        addCheck(1, 41, 25, randColor, randColor);
        addCheck(2, 95, 79, 12'h0f0, 12'h0f0);
        addCheck(3, 60, 20, 12'h111, 12'h111);     // unwritten tile
        addCheck(4, 10, 50, BORDER_COLOR, BORDER_COLOR);
        addCheck(5, 130, 10, 12'h000, 12'h000);    // horizontal blank
        addCheck(6, 57, 41, 12'habc, 12'habc);     // colour 0 sprite 0 does not mask it
        addCheck(7, 62, 46, 12'habc, 12'habc);     // lower index wins
        addCheck(8, 66, 50, 12'h5a5, 12'h5a5);
        addCheck(9, 53, 37, 12'h111, 12'h111);
        addCheck(10, 82, 26, 12'h111, 12'h111);
        addCheck(11, 74, 58, 12'h111, 12'hc3c);    // late sprite shows one frame later
        addCheck(12, 0, 0, BORDER_COLOR, BORDER_COLOR);
        addCheck(13, 127, 95, BORDER_COLOR, BORDER_COLOR);
    endtask

    task automatic checkIdleOutputs(inout int errs);
        checks += 4;
        if (vgaIntr !== 1'b0) begin
            errs++;
            $display("CHECK FAILED vgaIntr: got %h expected %h", vgaIntr, 1'b0);
        end
        if (rgb !== 12'h000) begin
            errs++;
            $display("CHECK FAILED rgb: got %h expected %h", rgb, 12'h000);
        end
        if (hsync !== 1'b1) begin
            errs++;
            $display("CHECK FAILED hsync: got %h expected %h", hsync, 1'b1);
        end
        if (vsync !== 1'b1) begin
            errs++;
            $display("CHECK FAILED vsync: got %h expected %h", vsync, 1'b1);
        end
    endtask

    task automatic runReset();
        int errs;
        errs = 0;
        repeat (8) begin
            @(posedge clk_50MHz);
            #2;
            checkIdleOutputs(errs);
        end
        rstn = 1'b1;
        @(posedge clk_50MHz);
        #2;
        checkIdleOutputs(errs);
        errors += errs;
        tests++;
        $display("test reset: %0d errors", errs);
    endtask

    task automatic applyWrites();
        for (int i = 0; i < N_WR; i++) begin
            wrEn     = 1'b1;
            wrTarget = wrTgtTbl[i];
            wrAddr   = wrAddrTbl[i];
            wrData   = wrDataTbl[i];
            @(posedge clk_50MHz);
            #2;
        end
        wrEn = 1'b0;
    endtask

    task automatic waitFall(input bit useV);
        bit prev;
        bit found;
        int n;
        if (timedOut)
            return;
        prev  = syncLevel(useV);
        found = 1'b0;
        n     = 0;
        while (!found && n < FRAME_CLKS + LINE_CLKS) begin
            @(posedge clk_50MHz);
            #2;
            found = prev && !syncLevel(useV);
            prev  = syncLevel(useV);
            n++;
        end
        if (!found) begin
            $display("timeout: no falling edge seen on %s", useV ? "vsync" : "hsync");
            timedOut = 1'b1;
        end
    endtask

    task automatic measureSync(input bit useV, input int expLow, input int expPeriod);
        int n;
        int lowLen;
        int period;
        int errs;
        waitFall(useV);
        if (timedOut)
            return;
        n = 0;
        lowLen = -1;
        period = -1;
        errs = 0;
        while (period < 0 && n < FRAME_CLKS + LINE_CLKS) begin
            @(posedge clk_50MHz);
            #2;
            n++;
            if (lowLen < 0 && syncLevel(useV))
                lowLen = n;
            else if (lowLen >= 0 && !syncLevel(useV))
                period = n;
        end
        if (period < 0) begin
            $display("timeout: %s pulse did not repeat", useV ? "vsync" : "hsync");
            timedOut = 1'b1;
            return;
        end
        checks += 2;
        if (lowLen != expLow) begin
            errs++;
            $display("CHECK FAILED %s low length: got %h expected %h",
                     useV ? "vsync" : "hsync", lowLen, expLow);
        end
        if (period != expPeriod) begin
            errs++;
            $display("CHECK FAILED %s period: got %h expected %h",
                     useV ? "vsync" : "hsync", period, expPeriod);
        end
        errors += errs;
        tests++;
        $display("test %s timing: %0d errors", useV ? "vsync" : "hsync", errs);
    endtask

    // starts on the clock where vsync has just fallen
    task automatic checkFrame(input bit second);
        int   target;
        int   irqCount;
        int   irqAt;
        int   pixErr;
        int   irqErr;
        rgb_t exp;
        if (timedOut)
            return;
        pixErr = 0;
        irqErr = 0;
        irqCount = 0;
        irqAt = -1;
        for (int cnt = 1; cnt < FRAME_CLKS; cnt++) begin
            @(posedge clk_50MHz);
            #2;
            if (!second && cnt == LATE_CLKS) begin
                wrEn     = 1'b1;
                wrTarget = WR_SPRITE;
                wrAddr   = 8'd3;
                wrData   = packSprite(1'b1, 40, 40, 12'hc3c);
            end
            if (!second && cnt == LATE_CLKS + 1)
                wrEn = 1'b0;
            if (vgaIntr) begin
                irqCount++;
                irqAt = cnt;
            end
            for (int i = 0; i < N_CHK; i++) begin
                target = 2 * (VBLANK_LINES * H_TOTAL + chkY[i] * H_TOTAL + chkX[i]);
                if (target == cnt) begin
                    exp = second ? expSecond[i] : expFirst[i];
                    checks++;
                    if (rgb !== exp) begin
                        pixErr++;
                        $display("CHECK FAILED rgb at (%0d,%0d): got %h expected %h",
                                 chkX[i], chkY[i], rgb, exp);
                    end
                end
            end
        end
        errors += pixErr;
        tests++;
        $display("test pixels frame %0d: %0d errors", second ? 2 : 1, pixErr);
        checks += 2;
        if (irqCount != 1) begin
            irqErr++;
            $display("CHECK FAILED vgaIntr high clocks: got %h expected %h", irqCount, 1);
        end
        if (irqAt != IRQ_CLKS) begin
            irqErr++;
            $display("CHECK FAILED vgaIntr position: got %h expected %h", irqAt, IRQ_CLKS);
        end
        errors += irqErr;
        tests++;
        $display("test interrupt frame %0d: %0d errors", second ? 2 : 1, irqErr);
    endtask

    initial begin
        clk_50MHz = 1'b0;
        rstn      = 1'b0;
        wrEn      = 1'b0;
        wrTarget  = WR_NAME;
        wrAddr    = '0;
        wrData    = '0;
        seed      = 10234;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timedOut  = 1'b0;
        randColor = rgb_t'($random(seed));
        buildTables();

        runReset();
        applyWrites();
        measureSync(1'b0, 2 * H_SYNC, 2 * H_TOTAL);
        // vsync measure ends on a vsync fall, frame checks start right there
        measureSync(1'b1, 2 * V_SYNC * H_TOTAL, FRAME_CLKS);
        checkFrame(1'b0);
        waitFall(1'b1);
        checkFrame(1'b1);

        $display("tests %0d, checks %0d, errors %0d, timeout %0d", tests, checks, errors, timedOut);
        if (errors == 0 && !timedOut)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- build.f
hw/ppuPkg.sv
hw/scanIf.sv
hw/scanTimer.sv
hw/frameSequencer.sv
hw/backgroundEngine.sv
hw/spriteEngine.sv
hw/pixelMixer.sv
hw/ppuTop.sv
sim/ppuProps.sv
sim/tb_ppuTop.sv

//--- run.sh
#!/bin/sh
# compile and run tb_ppuTop with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_ppuTop -f build.f -o tb_ppuTop \
    && ./obj_dir/tb_ppuTop > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
exit 0
